/* common/cpu16_macros.svh */
// Opcode patterns hold ? bits and are meant for casez only; CMPI and CMPUI match a zero nibble
`ifndef CPU16_MACROS_SVH
`define CPU16_MACROS_SVH

`define NUM_REGS 16

// Flag bit positions, Z C F L N from bit 4 down
`define FLAG_Z 4
`define FLAG_C 3
`define FLAG_F 2
`define FLAG_L 1
`define FLAG_N 0

// Opcode is {instr[15:12], instr[7:4]}
`define OPC_ADD    8'b0000_0101
`define OPC_ADDI   8'b0101_????
`define OPC_ADDU   8'b0000_0110
`define OPC_ADDUI  8'b0110_????
`define OPC_ADDC   8'b0000_0111
`define OPC_ADDCI  8'b0111_????
`define OPC_ADDCU  8'b0000_0100
`define OPC_ADDCUI 8'b1010_????
`define OPC_SUB    8'b0000_1001
`define OPC_SUBI   8'b1001_????
`define OPC_CMP    8'b0000_1011
`define OPC_CMPI   8'b1011_0000
`define OPC_CMPU   8'b0000_1000
`define OPC_CMPUI  8'b1100_0000
`define OPC_AND    8'b0000_0001
`define OPC_ANDI   8'b0001_????
`define OPC_OR     8'b0000_0010
`define OPC_ORI    8'b0010_????
`define OPC_XOR    8'b0000_0011
`define OPC_XORI   8'b0011_????
`define OPC_NOT    8'b0000_1111
`define OPC_LSH    8'b1000_0100
`define OPC_LSHI   8'b1000_000?
`define OPC_RSH    8'b1000_0101
`define OPC_RSHI   8'b1000_001?
`define OPC_ALSH   8'b1000_0110
`define OPC_ALSHI  8'b1000_100?
`define OPC_ARSH   8'b1000_0111
`define OPC_ARSHI  8'b1000_101?
`define OPC_LOAD   8'b0100_0000
`define OPC_STOR   8'b0100_0100
`define OPC_JALR   8'b0100_1000
`define OPC_JCOND  8'b0100_1100
`define OPC_NOP    8'b0000_0000

// Jcond condition codes in instr[11:8]; 4'b1111 never jumps
`define COND_EQ  4'b0000
`define COND_NE  4'b0001
`define COND_CS  4'b0010
`define COND_CC  4'b0011
`define COND_HI  4'b0100
`define COND_LS  4'b0101
`define COND_GT  4'b0110
`define COND_LE  4'b0111
`define COND_FS  4'b1000
`define COND_FC  4'b1001
`define COND_LO  4'b1010
`define COND_HS  4'b1011
`define COND_LT  4'b1100
`define COND_GE  4'b1101
`define COND_UNC 4'b1110

`endif

/* common/cpu16_pkg.sv */
// Core types; the register index width follows NUM_REGS and the flag order is Z C F L N
`default_nettype none

`include "cpu16_macros.svh"

package cpu16_pkg;

	typedef logic [15:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	// Upper opcode nibble, then extension bits 7 to 4
	typedef logic [7:0] opcode_t;

	typedef logic [4:0] flags_t;

	// Failed Jcond is reported as R_TYPE
	typedef enum logic [1:0] {
		R_TYPE = 2'b00,
		I_TYPE = 2'b01,
		P_TYPE = 2'b10,
		J_TYPE = 2'b11
	} instr_type_t;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_ADDC,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOT,
		OP_LSH,
		OP_RSH,
		OP_ALSH,
		OP_ARSH,
		OP_PASS_B
	} alu_op_t;

endpackage

`default_nettype wire

/* design/decoder.sv */
// Combinational only; unsigned forms share the signed ALU ops and invalid opcodes do nothing
`timescale 1ns/100ps
`default_nettype none

`include "cpu16_macros.svh"

module decoder (
	input  cpu16_pkg::word_t       instr,
	input  logic                   instr_valid,
	input  cpu16_pkg::flags_t      flags,
	output cpu16_pkg::reg_idx_t    rd_a_idx,
	output cpu16_pkg::reg_idx_t    rd_b_idx,
	output cpu16_pkg::reg_idx_t    wr_idx,
	output cpu16_pkg::alu_op_t     alu_op,
	output logic                   use_imm,
	output cpu16_pkg::word_t       imm,
	output logic                   set_flags,
	output logic                   wb_en,
	output logic                   wb_sel_mem,
	output logic                   wb_sel_link,
	output logic                   mem_we,
	output logic                   jump_taken,
	output cpu16_pkg::instr_type_t itype
);
	import cpu16_pkg::*;

	opcode_t opcode;
	logic    cond_met;
	logic    is_store;
	logic    arith_op;

	assign opcode = {instr[15:12], instr[7:4]};

	// Jcond condition over the stored flags
	always_comb
	begin
		case (instr[11:8])
			`COND_EQ:  cond_met = flags[`FLAG_Z];
			`COND_NE:  cond_met = !flags[`FLAG_Z];
			`COND_CS:  cond_met = flags[`FLAG_C];
			`COND_CC:  cond_met = !flags[`FLAG_C];
			`COND_HI:  cond_met = flags[`FLAG_L];
			`COND_LS:  cond_met = !flags[`FLAG_L];
			`COND_GT:  cond_met = flags[`FLAG_N];
			`COND_LE:  cond_met = !flags[`FLAG_N];
			`COND_FS:  cond_met = flags[`FLAG_F];
			`COND_FC:  cond_met = !flags[`FLAG_F];
			`COND_LO:  cond_met = !flags[`FLAG_L] && !flags[`FLAG_Z];
			`COND_HS:  cond_met = flags[`FLAG_L] || flags[`FLAG_Z];
			`COND_LT:  cond_met = !flags[`FLAG_N] && !flags[`FLAG_Z];
			`COND_GE:  cond_met = flags[`FLAG_N] || flags[`FLAG_Z];
			`COND_UNC: cond_met = 1'b1;
			default:   cond_met = 1'b0;
		endcase
	end

	// Instruction class, operand fields and write-back control
	always_comb
	begin
		rd_a_idx = instr[11:8];
		rd_b_idx = instr[3:0];
		wr_idx = instr[11:8];
		use_imm = 1'b0;
		imm = '0;
		itype = R_TYPE;
		wb_en = 1'b0;
		wb_sel_mem = 1'b0;
		wb_sel_link = 1'b0;
		is_store = 1'b0;
		casez (opcode)
			`OPC_ADDI, `OPC_ADDUI, `OPC_ADDCI, `OPC_ADDCUI, `OPC_SUBI,
			`OPC_CMPI, `OPC_CMPUI, `OPC_ANDI, `OPC_ORI, `OPC_XORI:
			begin
				use_imm = 1'b1;
				imm = {{8{instr[7]}}, instr[7:0]};
				itype = I_TYPE;
				wb_en = !(opcode == `OPC_CMPI || opcode == `OPC_CMPUI);
			end
			`OPC_LSHI, `OPC_RSHI, `OPC_ALSHI, `OPC_ARSHI:
			begin
				use_imm = 1'b1;
				// Shift amounts are unsigned
				imm = {11'd0, instr[4:0]};
				itype = I_TYPE;
				wb_en = 1'b1;
			end
			`OPC_ADD, `OPC_ADDU, `OPC_ADDC, `OPC_ADDCU, `OPC_SUB, `OPC_CMP, `OPC_CMPU,
			`OPC_AND, `OPC_OR, `OPC_XOR, `OPC_NOT, `OPC_LSH, `OPC_RSH, `OPC_ALSH,
			`OPC_ARSH, `OPC_NOP:
			begin
				wb_en = !(opcode == `OPC_CMP || opcode == `OPC_CMPU || opcode == `OPC_NOP);
			end
			`OPC_LOAD:
			begin
				itype = P_TYPE;
				wb_en = 1'b1;
				wb_sel_mem = 1'b1;
			end
			`OPC_STOR:
			begin
				itype = P_TYPE;
				is_store = 1'b1;
			end
			`OPC_JALR:
			begin
				itype = J_TYPE;
				wb_en = 1'b1;
				wb_sel_link = 1'b1;
			end
			// Untaken Jcond behaves as a NOP
			`OPC_JCOND: itype = cond_met ? J_TYPE : R_TYPE;
			default: itype = R_TYPE;
		endcase
	end

	// ALU operation, pass-through for anything without arithmetic
	always_comb
	begin
		casez (opcode)
			`OPC_ADD, `OPC_ADDI, `OPC_ADDU, `OPC_ADDUI:      alu_op = OP_ADD;
			`OPC_ADDC, `OPC_ADDCI, `OPC_ADDCU, `OPC_ADDCUI:  alu_op = OP_ADDC;
			`OPC_SUB, `OPC_SUBI, `OPC_CMP, `OPC_CMPI,
			`OPC_CMPU, `OPC_CMPUI:                           alu_op = OP_SUB;
			`OPC_AND, `OPC_ANDI:                             alu_op = OP_AND;
			`OPC_OR, `OPC_ORI:                               alu_op = OP_OR;
			`OPC_XOR, `OPC_XORI:                             alu_op = OP_XOR;
			`OPC_NOT:                                        alu_op = OP_NOT;
			`OPC_LSH, `OPC_LSHI:                             alu_op = OP_LSH;
			`OPC_RSH, `OPC_RSHI:                             alu_op = OP_RSH;
			`OPC_ALSH, `OPC_ALSHI:                           alu_op = OP_ALSH;
			`OPC_ARSH, `OPC_ARSHI:                           alu_op = OP_ARSH;
			default:                                         alu_op = OP_PASS_B;
		endcase
	end

	assign arith_op = (alu_op == OP_ADD) || (alu_op == OP_ADDC) || (alu_op == OP_SUB);

	// Side effects only for a valid instruction
	assign set_flags = instr_valid && arith_op;
	assign mem_we = instr_valid && is_store;
	assign jump_taken = instr_valid && (itype == J_TYPE);

	always_comb
	begin
		a_wb_store_excl: assert final (!(wb_en && mem_we))
		else $error("decoder: write-back and store requested together");
	end

endmodule

`default_nettype wire

/* design/regfile.sv */
// All registers clear on reset; reads are asynchronous and return the old value during a write
`timescale 1ns/100ps
`default_nettype none

`include "cpu16_macros.svh"

module regfile (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                wr_en,
	input  cpu16_pkg::reg_idx_t wr_idx,
	input  cpu16_pkg::word_t    wr_data,
	input  cpu16_pkg::reg_idx_t rd_a_idx,
	input  cpu16_pkg::reg_idx_t rd_b_idx,
	output cpu16_pkg::word_t    rd_a_data,
	output cpu16_pkg::word_t    rd_b_data
);
	import cpu16_pkg::*;

	word_t regs [`NUM_REGS];

	// One write port, taken at the edge
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_a_data = regs[rd_a_idx];
	assign rd_b_data = regs[rd_b_idx];

	a_wr_idx_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_idx)
	) else $error("regfile: write with unknown index");

endmodule

`default_nettype wire

/* design/alu.sv */
// Shifts use the low five bits of operand B; Z, L and N compare the operands, not the result
`timescale 1ns/100ps
`default_nettype none

`include "cpu16_macros.svh"

module alu (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu16_pkg::word_t   a,
	input  cpu16_pkg::word_t   b,
	input  cpu16_pkg::word_t   imm,
	input  logic               use_imm,
	input  cpu16_pkg::alu_op_t alu_op,
	input  logic               set_flags,
	output cpu16_pkg::flags_t  flags,
	output cpu16_pkg::word_t   result
);
	import cpu16_pkg::*;

	word_t        b_eff;
	logic [4:0]   shamt;
	logic         carry_in;
	logic [16:0]  add_full;
	logic [16:0]  sub_full;
	flags_t       flags_next;

	assign b_eff = use_imm ? imm : b;
	assign shamt = b_eff[4:0];

	// ADDC takes the stored carry
	assign carry_in = (alu_op == OP_ADDC) && flags[`FLAG_C];
	assign add_full = {1'b0, a} + {1'b0, b_eff} + {16'd0, carry_in};
	// Bit 16 is the borrow
	assign sub_full = {1'b0, a} - {1'b0, b_eff};

	always_comb
	begin
		case (alu_op)
			OP_ADD, OP_ADDC: result = add_full[15:0];
			OP_SUB:          result = sub_full[15:0];
			OP_AND:          result = a & b_eff;
			OP_OR:           result = a | b_eff;
			OP_XOR:          result = a ^ b_eff;
			OP_NOT:          result = ~b_eff;
			// Arithmetic left shift is the same as logical
			OP_LSH, OP_ALSH: result = a << shamt;
			OP_RSH:          result = a >> shamt;
			OP_ARSH:         result = $signed(a) >>> shamt;
			default:         result = b_eff;
		endcase
	end

	// CR16 compare sense for Z, L and N
	always_comb
	begin
		flags_next[`FLAG_Z] = (a == b_eff);
		flags_next[`FLAG_L] = (b_eff > a);
		flags_next[`FLAG_N] = ($signed(b_eff) > $signed(a));
		if (alu_op == OP_SUB)
		begin
			flags_next[`FLAG_C] = sub_full[16];
			flags_next[`FLAG_F] = (a[15] != b_eff[15]) && (sub_full[15] != a[15]);
		end
		else
		begin
			flags_next[`FLAG_C] = add_full[16];
			flags_next[`FLAG_F] = (a[15] == b_eff[15]) && (add_full[15] != a[15]);
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			flags <= '0;
		else if (set_flags)
			flags <= flags_next;
	end

	a_flags_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(flags)
	) else $error("alu: flag register holds X");

endmodule

`default_nettype wire

/* design/exec_core.sv */
// Single-cycle core; pc and instruction come from outside and there is no stall or back-pressure
`timescale 1ns/100ps
`default_nettype none

module exec_core (
	input  logic                clk,
	input  logic                arst_n,
	input  cpu16_pkg::word_t    instr,
	input  logic                instr_valid,
	input  cpu16_pkg::word_t    pc,
	input  cpu16_pkg::word_t    mem_rdata,
	output cpu16_pkg::word_t    mem_addr,
	output cpu16_pkg::word_t    mem_wdata,
	output logic                mem_we,
	output logic                jump_taken,
	output cpu16_pkg::word_t    jump_target,
	output logic                wb_en_o,
	output cpu16_pkg::reg_idx_t wb_idx,
	output cpu16_pkg::word_t    wb_data,
	output cpu16_pkg::flags_t   flags
);
	import cpu16_pkg::*;

	reg_idx_t    rd_a_idx;
	reg_idx_t    rd_b_idx;
	word_t       rd_a_data;
	word_t       rd_b_data;
	alu_op_t     alu_op;
	logic        use_imm;
	word_t       imm;
	logic        set_flags;
	logic        dec_wb_en;
	logic        wb_sel_mem;
	logic        wb_sel_link;
	word_t       alu_result;

	decoder decoder_i (
		.instr       (instr),
		.instr_valid (instr_valid),
		.flags       (flags),
		.rd_a_idx    (rd_a_idx),
		.rd_b_idx    (rd_b_idx),
		.wr_idx      (wb_idx),
		.alu_op      (alu_op),
		.use_imm     (use_imm),
		.imm         (imm),
		.set_flags   (set_flags),
		.wb_en       (dec_wb_en),
		.wb_sel_mem  (wb_sel_mem),
		.wb_sel_link (wb_sel_link),
		.mem_we      (mem_we),
		.jump_taken  (jump_taken),
		.itype       ()
	);

	regfile regfile_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.wr_en     (wb_en_o),
		.wr_idx    (wb_idx),
		.wr_data   (wb_data),
		.rd_a_idx  (rd_a_idx),
		.rd_b_idx  (rd_b_idx),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data)
	);

	alu alu_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.a         (rd_a_data),
		.b         (rd_b_data),
		.imm       (imm),
		.use_imm   (use_imm),
		.alu_op    (alu_op),
		.set_flags (set_flags),
		.flags     (flags),
		.result    (alu_result)
	);

	// Rb addresses memory and jumps, Ra is the store data
	assign mem_addr = rd_b_data;
	assign mem_wdata = rd_a_data;
	assign jump_target = rd_b_data;

	assign wb_en_o = instr_valid && dec_wb_en;

	// Link beats load beats ALU
	assign wb_data = wb_sel_link ? word_t'(pc + 16'd1) :
	                 wb_sel_mem  ? mem_rdata :
	                 alu_result;

endmodule

`default_nettype wire

/* tb/tb_exec_core.sv */
// Memory is a read-only 16-word array; random stimulus from seed 27, one instruction per cycle
`timescale 1ns/100ps
`default_nettype none

`include "cpu16_macros.svh"

module tb_exec_core;
	import cpu16_pkg::*;

	// ADD ADDU ADDC ADDCU SUB CMP CMPU AND OR XOR NOT
	localparam logic [3:0] r_ext_codes [11] = '{4'h5, 4'h6, 4'h7, 4'h4, 4'h9, 4'hB, 4'h8,
		4'h1, 4'h2, 4'h3, 4'hF};
	// ADDI ADDUI ADDCI ADDCUI SUBI ANDI ORI XORI
	localparam logic [3:0] i_upper_codes [8] = '{4'h5, 4'h6, 4'h7, 4'hA, 4'h9, 4'h1, 4'h2, 4'h3};
	// LSHI RSHI ALSHI ARSHI
	localparam logic [2:0] shi_codes [4] = '{3'b000, 3'b001, 3'b100, 3'b101};

	logic        clk;
	logic        arst_n;
	word_t       instr;
	logic        instr_valid;
	word_t       pc;
	word_t       mem_rdata;
	word_t       mem_addr;
	word_t       mem_wdata;
	logic        mem_we;
	logic        jump_taken;
	word_t       jump_target;
	logic        wb_en_o;
	reg_idx_t    wb_idx;
	word_t       wb_data;
	flags_t      flags;

	// Shadow state of the model
	word_t       model_regs [`NUM_REGS];
	flags_t      model_flags;
	word_t       mem [16];

	word_t       ra_val;
	word_t       rb_val;
	logic        exp_wb_en;
	word_t       exp_wb_data;
	logic        exp_set_flags;
	flags_t      exp_flags;
	logic        exp_mem_we;
	logic        exp_jump;

	exec_core exec_core_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.pc          (pc),
		.mem_rdata   (mem_rdata),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_we      (mem_we),
		.jump_taken  (jump_taken),
		.jump_target (jump_target),
		.wb_en_o     (wb_en_o),
		.wb_idx      (wb_idx),
		.wb_data     (wb_data),
		.flags       (flags)
	);

	always #20 clk = ~clk;

	assign mem_rdata = mem[mem_addr[3:0]];

	// Jcond table, 4'b1111 never jumps
	function automatic logic cond_holds(input logic [3:0] code, input flags_t f);
		case (code)
			`COND_EQ:  return f[`FLAG_Z];
			`COND_NE:  return !f[`FLAG_Z];
			`COND_CS:  return f[`FLAG_C];
			`COND_CC:  return !f[`FLAG_C];
			`COND_HI:  return f[`FLAG_L];
			`COND_LS:  return !f[`FLAG_L];
			`COND_GT:  return f[`FLAG_N];
			`COND_LE:  return !f[`FLAG_N];
			`COND_FS:  return f[`FLAG_F];
			`COND_FC:  return !f[`FLAG_F];
			`COND_LO:  return !f[`FLAG_L] && !f[`FLAG_Z];
			`COND_HS:  return f[`FLAG_L] || f[`FLAG_Z];
			`COND_LT:  return !f[`FLAG_N] && !f[`FLAG_Z];
			`COND_GE:  return f[`FLAG_N] || f[`FLAG_Z];
			`COND_UNC: return 1'b1;
			default:   return 1'b0;
		endcase
	endfunction

	assign ra_val = model_regs[instr[11:8]];
	assign rb_val = model_regs[instr[3:0]];

	// Expected response of the current instruction
	always_comb
	begin : model_comb
		word_t opb;
		word_t res;
		logic  is_sub;
		logic  carry;
		int    sum_u;
		int    sum_s;
		opb = rb_val;
		res = '0;
		is_sub = 1'b0;
		carry = 1'b0;
		exp_wb_en = 1'b0;
		exp_set_flags = 1'b0;
		exp_mem_we = 1'b0;
		exp_jump = 1'b0;
		casez ({instr[15:12], instr[7:4]})
			`OPC_ADDI, `OPC_ADDUI, `OPC_ADDCI, `OPC_ADDCUI, `OPC_SUBI, `OPC_CMPI, `OPC_CMPUI,
			`OPC_ANDI, `OPC_ORI, `OPC_XORI: opb = {{8{instr[7]}}, instr[7:0]};
			`OPC_LSHI, `OPC_RSHI, `OPC_ALSHI, `OPC_ARSHI: opb = {11'd0, instr[4:0]};
			default: opb = rb_val;
		endcase
		casez ({instr[15:12], instr[7:4]})
			`OPC_ADD, `OPC_ADDI, `OPC_ADDU, `OPC_ADDUI, `OPC_ADDC, `OPC_ADDCI, `OPC_ADDCU,
			`OPC_ADDCUI:
			begin
				carry = (instr[15:12] == 4'h7 || instr[15:12] == 4'hA ||
					(instr[15:12] == 4'h0 && (instr[7:4] == 4'h7 || instr[7:4] == 4'h4)))
					&& model_flags[`FLAG_C];
				res = ra_val + opb + carry;
				exp_wb_en = 1'b1;
				exp_set_flags = 1'b1;
			end
			`OPC_SUB, `OPC_SUBI, `OPC_CMP, `OPC_CMPI, `OPC_CMPU, `OPC_CMPUI:
			begin
				res = ra_val - opb;
				is_sub = 1'b1;
				exp_wb_en = (instr[15:12] == 4'h9) || (instr[15:12] == 4'h0 && instr[7:4] == 4'h9);
				exp_set_flags = 1'b1;
			end
			`OPC_AND, `OPC_ANDI: {exp_wb_en, res} = {1'b1, ra_val & opb};
			`OPC_OR, `OPC_ORI:   {exp_wb_en, res} = {1'b1, ra_val | opb};
			`OPC_XOR, `OPC_XORI: {exp_wb_en, res} = {1'b1, ra_val ^ opb};
			`OPC_NOT:            {exp_wb_en, res} = {1'b1, ~opb};
			`OPC_LSH, `OPC_LSHI, `OPC_ALSH, `OPC_ALSHI: {exp_wb_en, res} = {1'b1, ra_val << opb[4:0]};
			`OPC_RSH, `OPC_RSHI: {exp_wb_en, res} = {1'b1, ra_val >> opb[4:0]};
			`OPC_ARSH, `OPC_ARSHI: {exp_wb_en, res} = {1'b1, word_t'($signed(ra_val) >>> opb[4:0])};
			`OPC_LOAD:  {exp_wb_en, res} = {1'b1, mem[rb_val[3:0]]};
			`OPC_STOR:  exp_mem_we = 1'b1;
			`OPC_JALR:  {exp_wb_en, exp_jump, res} = {2'b11, word_t'(pc + 16'd1)};
			`OPC_JCOND: exp_jump = cond_holds(instr[11:8], model_flags);
			default:    res = '0;
		endcase
		// Signed and unsigned results at full width
		sum_u = is_sub ? (int'(ra_val) - int'(opb)) : (int'(ra_val) + int'(opb) + int'(carry));
		sum_s = is_sub ? (int'($signed(ra_val)) - int'($signed(opb)))
			: (int'($signed(ra_val)) + int'($signed(opb)) + int'(carry));
		exp_flags[`FLAG_Z] = (ra_val == opb);
		exp_flags[`FLAG_C] = is_sub ? (opb > ra_val) : (sum_u > 65535);
		exp_flags[`FLAG_F] = (sum_s > 32767) || (sum_s < -32768);
		exp_flags[`FLAG_L] = (opb > ra_val);
		exp_flags[`FLAG_N] = ($signed(opb) > $signed(ra_val));
		exp_wb_data = res;
		exp_wb_en = exp_wb_en && instr_valid;
		exp_set_flags = exp_set_flags && instr_valid;
		exp_mem_we = exp_mem_we && instr_valid;
		exp_jump = exp_jump && instr_valid;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
				model_regs[i] <= '0;
			model_flags <= '0;
		end
		else
		begin
			if (exp_wb_en)
				model_regs[instr[11:8]] <= exp_wb_data;
			if (exp_set_flags)
				model_flags <= exp_flags;
		end
	end

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] want);
		$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, want);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	a_flags: assert property (@(posedge clk) disable iff (!arst_n) flags == model_flags)
		else report_mismatch("flags", 16'($sampled(flags)), 16'($sampled(model_flags)));
	a_wb_en: assert property (@(posedge clk) disable iff (!arst_n) wb_en_o == exp_wb_en)
		else report_mismatch("wb_en_o", 16'($sampled(wb_en_o)), 16'($sampled(exp_wb_en)));
	a_wb_data: assert property (@(posedge clk) disable iff (!arst_n)
		exp_wb_en |-> wb_data == exp_wb_data)
		else report_mismatch("wb_data", $sampled(wb_data), $sampled(exp_wb_data));
	a_wb_idx: assert property (@(posedge clk) disable iff (!arst_n)
		exp_wb_en |-> wb_idx == instr[11:8])
		else report_mismatch("wb_idx", 16'($sampled(wb_idx)), 16'($sampled(instr[11:8])));
	a_mem_we: assert property (@(posedge clk) disable iff (!arst_n) mem_we == exp_mem_we)
		else report_mismatch("mem_we", 16'($sampled(mem_we)), 16'($sampled(exp_mem_we)));
	a_mem_addr: assert property (@(posedge clk) disable iff (!arst_n)
		exp_mem_we |-> mem_addr == rb_val)
		else report_mismatch("mem_addr", $sampled(mem_addr), $sampled(rb_val));
	a_mem_wdata: assert property (@(posedge clk) disable iff (!arst_n)
		exp_mem_we |-> mem_wdata == ra_val)
		else report_mismatch("mem_wdata", $sampled(mem_wdata), $sampled(ra_val));
	a_jump: assert property (@(posedge clk) disable iff (!arst_n) jump_taken == exp_jump)
		else report_mismatch("jump_taken", 16'($sampled(jump_taken)), 16'($sampled(exp_jump)));
	a_target: assert property (@(posedge clk) disable iff (!arst_n)
		exp_jump |-> jump_target == rb_val)
		else report_mismatch("jump_target", $sampled(jump_target), $sampled(rb_val));

	function automatic word_t rnd16();
		return word_t'($urandom);
	endfunction

	function automatic word_t rand_alu_instr();
		logic [3:0] rd;
		logic [3:0] rs;
		logic [7:0] lo;
		rd = 4'($urandom);
		rs = 4'($urandom);
		lo = 8'($urandom);
		case ($urandom_range(0, 4))
			0: return {4'h0, rd, r_ext_codes[$urandom_range(0, 10)], rs};
			1: return {i_upper_codes[$urandom_range(0, 7)], rd, lo};
			// CMPI and CMPUI need a zero extension nibble
			2: return {($urandom_range(0, 1) == 0) ? 4'hB : 4'hC, rd, 4'h0, lo[3:0]};
			3: return {4'h8, rd, 2'b01, 2'($urandom), rs};
			default: return {4'h8, rd, shi_codes[$urandom_range(0, 3)], lo[4:0]};
		endcase
	endfunction

	// One instruction for one cycle, driven after the edge
	task automatic issue(input word_t ins, input logic valid, input word_t pc_val);
		instr = ins;
		instr_valid = valid;
		pc = pc_val;
		@(posedge clk);
		#2;
	endtask

	initial
	begin
		void'($urandom(27));
		clk = 1'b0;
		arst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		pc = '0;
		for (int i = 0; i < 16; i++)
			mem[i] = rnd16();
		repeat (3) @(posedge clk);
		#2;
		arst_n = 1'b1;
		repeat (3) issue(rnd16(), 1'b0, rnd16());
		// Chained loads spread memory words over the registers
		for (int r = 0; r < `NUM_REGS; r++)
			issue({4'h4, 4'(r), 4'h0, 4'(r + 15)}, 1'b1, rnd16());
		repeat (400) issue(rand_alu_instr(), 1'b1, rnd16());
		issue({4'h0, 4'd1, 4'h5, 4'd2}, 1'b1, rnd16());
		issue({4'h0, 4'd3, 4'h9, 4'd4}, 1'b1, rnd16());
		issue({4'h0, 4'd5, 4'hB, 4'd5}, 1'b1, rnd16());
		issue({4'h0, 4'd6, 4'hB, 4'd7}, 1'b1, rnd16());
		repeat (20)
		begin
			issue({4'h4, 4'($urandom), 4'h4, 4'($urandom)}, 1'b1, rnd16());
			issue({4'h4, 4'($urandom), 4'h0, 4'($urandom)}, 1'b1, rnd16());
		end
		repeat (10) issue({4'h4, 4'($urandom), 4'h8, 4'($urandom)}, 1'b1, rnd16());
		issue({4'h4, 4'd9, 4'h8, 4'd10}, 1'b1, 16'hFFFF);
		// Every condition code against fresh compare flags
		for (int c = 0; c < 16; c++)
		begin
			repeat (6)
			begin
				if ($urandom_range(0, 2) == 0)
					issue({4'h0, 4'd8, 4'hB, 4'd8}, 1'b1, rnd16());
				else
					issue({4'h0, 4'($urandom), 4'hB, 4'($urandom)}, 1'b1, rnd16());
				issue({4'h4, 4'(c), 4'hC, 4'($urandom)}, 1'b1, rnd16());
			end
		end
		repeat (10) issue({4'hE, 12'($urandom)}, 1'b1, rnd16());
		repeat (5) issue({4'h0, 4'($urandom), 4'hA, 4'($urandom)}, 1'b1, rnd16());
		repeat (30) issue(rnd16(), 1'b0, rnd16());
		// ADDI Rn, 0 reads every register back
		for (int r = 0; r < `NUM_REGS; r++)
			issue({4'h5, 4'(r), 8'h00}, 1'b1, rnd16());
		issue('0, 1'b0, '0);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/cpu16_pkg.sv
design/decoder.sv
design/regfile.sv
design/alu.sv
design/exec_core.sv
tb/tb_exec_core.sv

/* Makefile */
# Verilator build for the exec_core project

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_exec_core
RTL_TOP   ?= exec_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
